//--- rtl/periph_pkg.sv
// peripheral package
// shared bus types, peripheral select record, region codes and the
// arbiter state encoding for the video clock peripheral block

package periph_pkg;

    typedef logic [23:0] host_addr_t;
    typedef logic [31:0] host_data_t;
    typedef logic [3:0]  host_strb_t;

    // host request, held steady by the host until ready
    typedef struct packed {
        logic       valid;
        host_addr_t address;
        host_strb_t wstrb;
        host_data_t write_data;
    } host_req_t;

    typedef struct packed {
        logic       ready;
        host_data_t read_data;
    } host_rsp_t;

    // one accepted request, fanned out to every peripheral
    typedef struct packed {
        logic       dsp;
        logic       pad;
        logic       status;
        logic       none;
        logic       write;
        logic       reg_index;
        host_data_t write_data;
    } periph_sel_t;

    // address bits 19 to 16
    typedef logic [3:0] region_t;

    localparam region_t REGION_STATUS = 4'd1;
    localparam region_t REGION_DSP    = 4'd2;
    localparam region_t REGION_PAD    = 4'd3;

    typedef struct packed {
        logic left;
        logic right;
        logic b;
    } pad_buttons_t;

    // bit 0 red, bit 1 blue
    typedef logic [1:0] led_status_t;

    typedef enum logic [1:0] {
        IDLE,
        RESPOND,
        WAIT_DROP
    } arb_state_t;

endpackage

//--- rtl/periph_decoder.sv
// peripheral address decoder
// registers each newly accepted host request into a one-hot peripheral
// select with a single cycle strobe

`timescale 1ns/1ps

module periph_decoder (
    input  logic                    vdp_clk,
    input  logic                    vdp_reset,
    input  periph_pkg::host_req_t   req,
    input  logic                    busy,
    output periph_pkg::periph_sel_t sel,
    output logic                    sel_valid
);

    periph_pkg::region_t     region;
    periph_pkg::periph_sel_t sel_next;
    logic                    accept;
    logic                    upper_clear;

    assign region      = req.address[19:16];
    assign upper_clear = (req.address[23:20] == 4'h0);

    // busy covers the whole transaction, so valid with busy low is a new request
    assign accept = req.valid && !busy;

    always_comb begin
        sel_next            = '0;
        sel_next.write      = |req.wstrb;
        sel_next.reg_index  = req.address[2];
        sel_next.write_data = req.write_data;

        if (!upper_clear) begin
            sel_next.none = 1'b1;
        end else begin
            case (region)
                periph_pkg::REGION_STATUS: sel_next.status = 1'b1;
                periph_pkg::REGION_DSP:    sel_next.dsp    = 1'b1;
                periph_pkg::REGION_PAD:    sel_next.pad    = 1'b1;
                default:                   sel_next.none   = 1'b1;
            endcase
        end
    end

    // strobe lasts exactly one cycle per accepted request
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= accept;
        end
    end

    // decode is held until the next accepted request
    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            sel <= sel_next;
        end
    end

endmodule

//--- rtl/dsp_mult.sv
// signed multiplier peripheral
// two writable operand registers feeding a product register that is
// updated every cycle

`timescale 1ns/1ps

module dsp_mult #(
    parameter int OPERAND_WIDTH = 16
) (
    input  logic                    vdp_clk,
    input  logic                    vdp_reset,
    input  periph_pkg::periph_sel_t sel,
    input  logic                    sel_valid,
    output periph_pkg::host_data_t  product
);

    logic signed [OPERAND_WIDTH-1:0] operand_a;
    logic signed [OPERAND_WIDTH-1:0] operand_b;
    periph_pkg::host_data_t          product_q;
    logic                            write_a;
    logic                            write_b;

    assign write_a = sel_valid && sel.dsp && sel.write && !sel.reg_index;
    assign write_b = sel_valid && sel.dsp && sel.write && sel.reg_index;

    // kept as single-enable registers so they fold into the multiplier inputs
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            operand_a <= '0;
        end else if (write_a) begin
            operand_a <= sel.write_data[OPERAND_WIDTH-1:0];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            operand_b <= '0;
        end else if (write_b) begin
            operand_b <= sel.write_data[OPERAND_WIDTH-1:0];
        end
    end

    // both operands signed, so the 32-bit context sign-extends them
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            product_q <= '0;
        end else begin
            product_q <= operand_a * operand_b;
        end
    end

    assign product = product_q;

endmodule

//--- rtl/board_io.sv
// board I/O peripheral
// gamepad latch and shift register fed from the board buttons, plus the
// two-bit LED status register

`timescale 1ns/1ps

module board_io #(
    parameter int PAD_BITS = 16
) (
    input  logic                     vdp_clk,
    input  logic                     vdp_reset,
    input  periph_pkg::periph_sel_t  sel,
    input  logic                     sel_valid,
    input  periph_pkg::pad_buttons_t buttons,
    output periph_pkg::host_data_t   pad_data,
    output logic                     led_r,
    output logic                     led_b
);

    periph_pkg::led_status_t status;
    logic [PAD_BITS-1:0]     pad_shift;
    logic [PAD_BITS-1:0]     pad_load;
    logic                    pad_latch;
    logic                    pad_clk;
    logic                    pad_clk_q;
    logic                    pad_clk_rise;
    logic                    pad_write;
    logic                    status_write;

    assign pad_write    = sel_valid && sel.pad && sel.write;
    assign status_write = sel_valid && sel.status && sel.write;

    // pad control, bit 0 latch and bit 1 clock
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_latch <= 1'b0;
            pad_clk   <= 1'b0;
        end else if (pad_write) begin
            pad_latch <= sel.write_data[0];
            pad_clk   <= sel.write_data[1];
        end
    end

    // button placement in the shift word
    always_comb begin
        pad_load    = '0;
        pad_load[7] = buttons.left;
        pad_load[6] = buttons.right;
        pad_load[0] = buttons.b;
    end

    assign pad_clk_rise = pad_clk && !pad_clk_q;

    // a clock rise wins over a held latch
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_shift <= '0;
            pad_clk_q <= 1'b0;
        end else begin
            if (pad_clk_rise) begin
                pad_shift <= {1'b0, pad_shift[PAD_BITS-1:1]};
            end else if (pad_latch) begin
                pad_shift <= pad_load;
            end
            pad_clk_q <= pad_clk;
        end
    end

    assign pad_data = {{($bits(periph_pkg::host_data_t) - 1){1'b0}}, pad_shift[0]};

    // red on, blue off out of reset
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= 2'b01;
        end else if (status_write) begin
            status <= sel.write_data[1:0];
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];

endmodule

//--- rtl/periph_arbiter.sv
// peripheral bus arbiter
// tracks the single request in flight, pulses ready once and returns the
// selected peripheral's read data

`timescale 1ns/1ps

module periph_arbiter (
    input  logic                    vdp_clk,
    input  logic                    vdp_reset,
    input  periph_pkg::periph_sel_t sel,
    input  logic                    sel_valid,
    input  logic                    host_valid,
    input  periph_pkg::host_data_t  product,
    input  periph_pkg::host_data_t  pad_data,
    output periph_pkg::host_rsp_t   rsp,
    output logic                    busy
);

    periph_pkg::arb_state_t state;
    periph_pkg::arb_state_t state_next;
    periph_pkg::host_data_t read_data;
    logic                   ready;

    always_comb begin
        state_next = state;
        case (state)
            periph_pkg::IDLE: begin
                if (sel_valid) begin
                    state_next = periph_pkg::RESPOND;
                end
            end
            periph_pkg::RESPOND: begin
                state_next = periph_pkg::WAIT_DROP;
            end
            periph_pkg::WAIT_DROP: begin
                // host holding valid keeps us here
                if (!host_valid) begin
                    state_next = periph_pkg::IDLE;
                end
            end
            default: begin
                state_next = periph_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= periph_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign ready = (state == periph_pkg::RESPOND);

    // writes, status reads and unmapped addresses all read as zero
    always_comb begin
        read_data = '0;
        if (ready && !sel.write) begin
            if (sel.dsp) begin
                read_data = product;
            end else if (sel.pad) begin
                read_data = pad_data;
            end
        end
    end

    assign rsp  = '{ready: ready, read_data: read_data};

    // covers the strobe cycle before the state machine leaves idle
    assign busy = sel_valid || (state != periph_pkg::IDLE);

endmodule

//--- rtl/periph_top.sv
// video clock peripheral block
// host bus decoder, signed multiplier, board I/O and response arbiter

`timescale 1ns/1ps

module periph_top #(
    parameter int OPERAND_WIDTH = 16,
    parameter int PAD_BITS      = 16
) (
    input  logic                     vdp_clk,
    input  logic                     vdp_reset,
    input  periph_pkg::host_req_t    req,
    output periph_pkg::host_rsp_t    rsp,
    input  periph_pkg::pad_buttons_t buttons,
    output logic                     led_r,
    output logic                     led_b
);

    periph_pkg::periph_sel_t sel;
    logic                    sel_valid;
    logic                    busy;
    periph_pkg::host_data_t  product;
    periph_pkg::host_data_t  pad_data;

    periph_decoder decoder (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .req       (req),
        .busy      (busy),
        .sel       (sel),
        .sel_valid (sel_valid)
    );

    dsp_mult #(
        .OPERAND_WIDTH (OPERAND_WIDTH)
    ) mult (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .sel       (sel),
        .sel_valid (sel_valid),
        .product   (product)
    );

    board_io #(
        .PAD_BITS (PAD_BITS)
    ) io (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .sel       (sel),
        .sel_valid (sel_valid),
        .buttons   (buttons),
        .pad_data  (pad_data),
        .led_r     (led_r),
        .led_b     (led_b)
    );

    // host valid goes straight in so the arbiter can see it drop
    periph_arbiter arbiter (
        .vdp_clk    (vdp_clk),
        .vdp_reset  (vdp_reset),
        .sel        (sel),
        .sel_valid  (sel_valid),
        .host_valid (req.valid),
        .product    (product),
        .pad_data   (pad_data),
        .rsp        (rsp),
        .busy       (busy)
    );

endmodule

//--- test/periph_assertions.sv
// bus handshake and reset checks
// bound into the peripheral top level, watching the host request,
// the response and the LED outputs

`timescale 1ns/1ps

module periph_assertions (
    input logic                  vdp_clk,
    input logic                  vdp_reset,
    input periph_pkg::host_req_t req,
    input periph_pkg::host_rsp_t rsp,
    input logic                  led_r,
    input logic                  led_b
);

    // failed assertions so far, read by the testbench summary
    int error_count;

    initial begin
        error_count = 0;
    end

    // one pulse per request
    single_ready: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        rsp.ready |=> !rsp.ready)
        else begin
            error_count++;
            $error("ready stayed high for two cycles");
        end

    ready_needs_valid: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        rsp.ready |-> req.valid)
        else begin
            error_count++;
            $error("ready high while valid low");
        end

    // decoder edge then arbiter edge
    fixed_latency: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(req.valid) |-> !rsp.ready ##1 !rsp.ready ##1 rsp.ready)
        else begin
            error_count++;
            $error("ready did not follow valid after two edges");
        end

    ready_low_in_reset: assert property (@(posedge vdp_clk)
        vdp_reset |=> !rsp.ready)
        else begin
            error_count++;
            $error("ready high after a reset cycle");
        end

    leds_after_reset: assert property (@(posedge vdp_clk)
        $fell(vdp_reset) |-> (led_r && !led_b))
        else begin
            error_count++;
            $error("LEDs not red on and blue off after reset");
        end

endmodule

//--- test/periph_tb.sv
// peripheral block testbench
// table-driven host bus requests against the multiplier, gamepad and LED
// registers, with a cycle watchdog and an error summary

`timescale 1ns/1ps

module periph_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;

    localparam periph_pkg::host_addr_t STATUS_ADDR   = 24'h010000;
    localparam periph_pkg::host_addr_t DSP_A_ADDR    = 24'h020000;
    localparam periph_pkg::host_addr_t DSP_B_ADDR    = 24'h020004;
    localparam periph_pkg::host_addr_t PAD_ADDR      = 24'h030000;
    localparam periph_pkg::host_addr_t UNMAPPED_ADDR = 24'h050000;
    localparam periph_pkg::host_addr_t HIGH_ADDR     = 24'h120000;

    logic                     vdp_clk;
    logic                     vdp_reset;
    periph_pkg::host_req_t    req;
    periph_pkg::host_rsp_t    rsp;
    periph_pkg::pad_buttons_t buttons;
    logic                     led_r;
    logic                     led_b;

    // stimulus table, one entry per request
    string                    row_name[$];
    bit                       row_write[$];
    periph_pkg::host_addr_t   row_addr[$];
    periph_pkg::host_data_t   row_data[$];
    periph_pkg::pad_buttons_t row_buttons[$];
    periph_pkg::host_data_t   row_expect[$];
    periph_pkg::led_status_t  row_led[$];

    periph_pkg::led_status_t  led_model;
    periph_pkg::host_data_t   last_product;
    periph_pkg::host_data_t   read_data;
    logic [31:0]              rng_state;
    int                       mismatch_count;
    int                       failure_count;
    int                       assertion_count;
    int                       watchdog_cycles;

    periph_top uut (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .req       (req),
        .rsp       (rsp),
        .buttons   (buttons),
        .led_r     (led_r),
        .led_b     (led_b)
    );

    bind periph_top periph_assertions handshake_checks (.*);

    initial begin
        vdp_clk = 1'b0;
        forever #(CLK_PERIOD / 2) vdp_clk = ~vdp_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic periph_pkg::host_data_t signed_product(input logic [15:0] a,
                                                              input logic [15:0] b);
        logic signed [31:0] wide_a;
        logic signed [31:0] wide_b;
        wide_a = {{16{a[15]}}, a};
        wide_b = {{16{b[15]}}, b};
        return wide_a * wide_b;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic add_row(input string name, input bit write,
                           input periph_pkg::host_addr_t addr,
                           input periph_pkg::host_data_t data,
                           input periph_pkg::pad_buttons_t btn,
                           input periph_pkg::host_data_t expected);
        // status writes move the expected LED state for this and later rows
        if (write && addr == STATUS_ADDR) begin
            led_model = data[1:0];
        end
        row_name.push_back(name);
        row_write.push_back(write);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_buttons.push_back(btn);
        row_expect.push_back(expected);
        row_led.push_back(led_model);
    endtask

    // upper data bits are junk, only the low 16 reach the operands
    task automatic add_mult(input string name, input logic [15:0] a, input logic [15:0] b);
        last_product = signed_product(a, b);
        add_row({name, " op a"}, 1'b1, DSP_A_ADDR, {16'hA5A5, a}, '0, '0);
        add_row({name, " op b"}, 1'b1, DSP_B_ADDR, {16'h5A5A, b}, '0, '0);
        add_row({name, " product"}, 1'b0, DSP_A_ADDR, '0, '0, last_product);
    endtask

    task automatic add_pad_sequence(input string name, input periph_pkg::pad_buttons_t btn);
        periph_pkg::host_data_t expected;
        add_row({name, " latch high"}, 1'b1, PAD_ADDR, 32'h1, btn, '0);
        add_row({name, " latch low"}, 1'b1, PAD_ADDR, 32'h0, btn, '0);
        add_row({name, " b"}, 1'b0, PAD_ADDR, '0, btn, {31'b0, btn.b});
        for (int i = 1; i <= 8; i++) begin
            add_row($sformatf("%s clock high %0d", name, i), 1'b1, PAD_ADDR, 32'h2, btn, '0);
            add_row($sformatf("%s clock low %0d", name, i), 1'b1, PAD_ADDR, 32'h0, btn, '0);
            // right sits six places up, left seven
            expected = '0;
            if (i == 6) begin
                expected = {31'b0, btn.right};
            end else if (i == 7) begin
                expected = {31'b0, btn.left};
            end
            if (i == 1 || i >= 6) begin
                add_row($sformatf("%s read %0d", name, i), 1'b0, PAD_ADDR, '0, btn, expected);
            end
        end
    endtask

    task automatic build_table();
        logic [15:0] rand_a;
        logic [15:0] rand_b;
        add_row("status read after reset", 1'b0, STATUS_ADDR, '0, '0, '0);
        add_row("status write blue", 1'b1, STATUS_ADDR, 32'h2, '0, '0);
        add_mult("mult small", 16'd3, 16'd5);
        add_row("status write both", 1'b1, STATUS_ADDR, 32'hFFFF_FFF3, '0, '0);
        add_row("product after status write", 1'b0, DSP_A_ADDR, '0, '0, last_product);
        add_mult("mult negative a", 16'hFFF9, 16'd300);
        add_mult("mult both negative", 16'hFF38, 16'hFC18);
        add_mult("mult min squared", 16'h8000, 16'h8000);
        add_mult("mult max by min", 16'h7FFF, 16'h8000);
        for (int i = 0; i < 6; i++) begin
            rng_state = lcg_next(rng_state);
            rand_a    = rng_state[31:16];
            rng_state = lcg_next(rng_state);
            rand_b    = rng_state[31:16];
            add_mult($sformatf("mult random %0d", i), rand_a, rand_b);
        end
        add_row("dsp read reg 1", 1'b0, DSP_B_ADDR, '0, '0, last_product);
        add_row("unmapped region read", 1'b0, UNMAPPED_ADDR, '0, '0, '0);
        add_row("upper bits set read", 1'b0, HIGH_ADDR, '0, '0, '0);
        add_row("unmapped write", 1'b1, UNMAPPED_ADDR, 32'hFFFF_FFFF, '0, '0);
        add_pad_sequence("pad 101", 3'b101);
        add_pad_sequence("pad 010", 3'b010);
        add_row("status write red", 1'b1, STATUS_ADDR, 32'h1, '0, '0);
        add_row("product after pad", 1'b0, DSP_A_ADDR, '0, '0, last_product);
    endtask

    // called on a falling edge, returns on a falling edge with the bus idle
    task automatic run_request(input string name, input bit write,
                               input periph_pkg::host_addr_t addr,
                               input periph_pkg::host_data_t data,
                               output periph_pkg::host_data_t result);
        int edges;
        edges  = 0;
        result = '0;
        req.valid      = 1'b1;
        req.address    = addr;
        req.wstrb      = write ? 4'hF : 4'h0;
        req.write_data = data;
        while (!rsp.ready && edges < 2) begin
            @(negedge vdp_clk);
            edges++;
        end
        if (!rsp.ready) begin
            $display("%s: no ready within 2 clock edges of valid", name);
            failure_count++;
        end else begin
            check_value({name, " latency"}, 32'd2, edges);
            result = rsp.read_data;
        end
        // host drops valid in the cycle after ready
        @(negedge vdp_clk);
        check_value({name, " ready pulse"}, 32'd0, rsp.ready);
        req = '0;
        repeat (2) @(negedge vdp_clk);
    endtask

    initial begin
        vdp_reset       = 1'b1;
        req             = '0;
        buttons         = '0;
        mismatch_count  = 0;
        failure_count   = 0;
        assertion_count = 0;
        watchdog_cycles = 0;
        led_model       = 2'b01;
        last_product    = '0;
        rng_state       = 32'd91859;
        build_table();
        watchdog_cycles = row_name.size() * 20 + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge vdp_clk);
        @(negedge vdp_clk);
        vdp_reset = 1'b0;
        check_value("reset ready", 32'd0, rsp.ready);
        check_value("reset leds", 32'd1, {30'b0, led_b, led_r});

        for (int i = 0; i < row_name.size(); i++) begin
            buttons = row_buttons[i];
            run_request(row_name[i], row_write[i], row_addr[i], row_data[i], read_data);
            check_value(row_name[i], row_expect[i], read_data);
            check_value({row_name[i], " leds"}, {30'b0, row_led[i]}, {30'b0, led_b, led_r});
        end

        assertion_count = uut.handshake_checks.error_count;
        $display("summary: %0d rows, %0d mismatches, %0d other failures, %0d assertion failures",
                 row_name.size(), mismatch_count, failure_count, assertion_count);
        if (mismatch_count == 0 && failure_count == 0 && assertion_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // limit scales with the table length
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge vdp_clk);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- list.f
rtl/periph_pkg.sv
rtl/periph_decoder.sv
rtl/dsp_mult.sv
rtl/board_io.sv
rtl/periph_arbiter.sv
rtl/periph_top.sv
test/periph_assertions.sv
test/periph_tb.sv

//--- Bender.yml
package:
  name: periph_block

sources:
  # design sources in compile order
  - files:
      - rtl/periph_pkg.sv
      - rtl/periph_decoder.sv
      - rtl/dsp_mult.sv
      - rtl/board_io.sv
      - rtl/periph_arbiter.sv
      - rtl/periph_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - test/periph_assertions.sv
      - test/periph_tb.sv

# simulation top: periph_tb
# design top: periph_top
# file list for simulators: list.f
